// File: board_top.sv
`timescale 1ns/1ps

module board_top (
    input  logic       clk_col16x_ntsc,
    input  logic       rst,
    output logic       cpu_reset,       // holds the 6510 in reset with us
    output logic       clk_phi,
    input  logic [5:0] adl_IN,          // cpu register address
    output logic [5:0] adl_OUT,
    output logic [5:0] adl_OE,
    output logic [5:0] adh,             // high address, always driven
    input  logic [7:0] dbl_IN,
    output logic [7:0] dbl_OUT,
    output logic [7:0] dbl_OE,
    input  logic [3:0] dbh,             // color ram nibble
    input  logic       ce,
    input  logic       rw,
    output logic       irq,
    output logic       aec,
    output logic       ba,
    output logic       cas,
    output logic       ras,
    output logic       ls245_addr_dir,
    output logic       ls245_data_dir,
    output logic       ls245_addr_oe,
    output logic       ls245_data_oe,
    output logic [5:0] luma,
    output logic [5:0] chroma
);
    import vic_pkg::*;

    addr_t ado;
    byte_t dbo;
    logic  vic_write_ab;
    logic  vic_write_db;

    vic_core u_core (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst             (rst),
        .ce              (ce),
        .rw              (rw),
        .adi             (reg_addr_e'(adl_IN)),  // unmapped codes read as ff
        .dbi             (dbl_IN),
        .dbh             (dbh),
        .dbo             (dbo),
        .ado             (ado),
        .vic_write_ab    (vic_write_ab),
        .vic_write_db    (vic_write_db),
        .clk_phi         (clk_phi),
        .aec             (aec),
        .ba              (ba),
        .ras             (ras),
        .cas             (cas),
        .irq             (irq),
        .luma            (luma),
        .chroma          (chroma)
    );

    assign cpu_reset = rst;

    assign adl_OUT = ado[5:0];            // fetch address low
    assign adh     = ado[11:6];
    assign adl_OE  = {6{vic_write_ab}};
    assign dbl_OUT = dbo;                 // cpu register read
    assign dbl_OE  = {8{vic_write_db}};

    // transceivers always enabled, direction follows who drives
    assign ls245_addr_oe  = 1'b0;
    assign ls245_data_oe  = 1'b0;
    assign ls245_addr_dir = !vic_write_ab;
    assign ls245_data_dir = !vic_write_db;

endmodule

// File: color_encoder.sv
`timescale 1ns/1ps

module color_encoder (
    input  logic            clk_col16x_ntsc,
    input  logic            rst,
    fetch_if.enc            fetch,
    input  vic_pkg::color_t border,
    input  vic_pkg::color_t background,
    output vic_pkg::luma_t  luma,
    output vic_pkg::luma_t  chroma
);
    import vic_pkg::*;

    byte_t      fifo_byte  [FIFO_DEPTH];
    color_t     fifo_color [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    credit_t    count;       // fifo occupancy
    byte_t      sh_byte;     // msb is the current pixel
    color_t     sh_color;
    logic [3:0] bits_left;   // 0 means shifter empty
    logic       div;         // second clock of a pixel
    logic       pop;
    color_t     pix;

    // reload on the last clock of the last pixel so bytes run back to back
    assign pop = (count != '0) && ((bits_left == '0) || (bits_left == 4'd1 && div));
    assign fetch.credit_ret = pop;

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (fetch.valid)
        begin
            fifo_byte[wr_ptr]  <= fetch.pix_byte;
            fifo_color[wr_ptr] <= fetch.pix_color;
        end
    end

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (fetch.valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (fetch.valid && !pop)
                count <= count + 3'd1;
            else if (!fetch.valid && pop)
                count <= count - 3'd1;
        end
    end

    // 8 pixels of 2 clocks fill one phi
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (rst)
        begin
            bits_left <= '0;
            div       <= 1'b0;
        end
        else if (pop)
        begin
            bits_left <= 4'd8;
            div       <= 1'b0;
        end
        else if (bits_left != '0)
        begin
            div <= !div;
            if (div)
                bits_left <= bits_left - 4'd1;
        end
    end

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (pop)
        begin
            sh_byte  <= fifo_byte[rd_ptr];
            sh_color <= fifo_color[rd_ptr];
        end
        else if (div)
            sh_byte <= sh_byte << 1;
    end

    always_comb
    begin
        if (bits_left == '0)
            pix = border;      // nothing in the shifter
        else if (sh_byte[7])
            pix = sh_color;
        else
            pix = background;
    end

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (rst)
        begin
            luma   <= LUMA_TAB[0];  // border color 0 out of reset
            chroma <= CHROMA_TAB[0];
        end
        else
        begin
            luma   <= LUMA_TAB[pix];
            chroma <= CHROMA_TAB[pix];
        end
    end

    // the sequencer credit count must keep the fifo from overflowing
    assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
        fetch.valid |-> count != credit_t'(FIFO_DEPTH));

endmodule

// File: fetch_if.sv
`timescale 1ns/1ps

// byte stream from the sequencer into the encoder fifo
interface fetch_if;
    import vic_pkg::*;

    logic   valid;       // one clock per fetched byte
    byte_t  pix_byte;    // pixel pattern, msb first
    color_t pix_color;   // foreground from the color ram nibble
    logic   credit_ret;  // one clock per fifo pop

    // sequencer side, spends credits
    modport seq (
        output valid,
        output pix_byte,
        output pix_color,
        input  credit_ret
    );

    // encoder side, hands credits back
    modport enc (
        input  valid,
        input  pix_byte,
        input  pix_color,
        output credit_ret
    );

endinterface

// File: fetch_seq.sv
`timescale 1ns/1ps

module fetch_seq (
    input  logic             clk_col16x_ntsc,
    input  logic             rst,
    output logic             clk_phi,
    output logic             phi_high,
    output logic             aec,
    output logic             ba,
    output logic             ras,
    output logic             cas,
    output vic_pkg::raster_t raster,
    output logic             line_start,
    input  vic_pkg::color_t  video_base,
    output vic_pkg::addr_t   ado,
    output logic             vic_write_ab,
    input  vic_pkg::byte_t   dbi,
    input  vic_pkg::color_t  dbh,
    fetch_if.seq             fetch
);
    import vic_pkg::*;

    logic [3:0] clk_cnt;    // clock within phi
    logic [3:0] clk_nxt;
    logic [5:0] phi_cnt;    // phi within line
    logic [5:0] col;        // text column being fetched
    logic       phi_end;
    logic       disp_line;
    logic       take;
    logic       slot;       // this phi owns a fetch
    logic       dec;
    credit_t    credit;
    seq_state_e state;

    assign clk_nxt    = clk_cnt + 4'd1;
    assign phi_end    = (clk_cnt == 4'(PHI_CLKS - 1));
    assign phi_high   = clk_cnt[3];
    assign aec        = clk_phi;  // video owns the bus while phi is low
    assign line_start = (clk_cnt == '0) && (phi_cnt == '0);
    assign disp_line  = (raster >= raster_t'(DISP_FIRST)) && (raster <= raster_t'(DISP_LAST));
    assign take       = (state == FETCH) && (credit != '0);  // no credit, skip the slot
    assign dec        = slot && (clk_cnt == 4'd6);
    assign ba         = (state == IDLE);
    assign ado        = vic_write_ab ? {video_base, 2'b00, col} : '0;

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (rst)
        begin
            clk_cnt <= '0;
            phi_cnt <= '0;
            raster  <= '0;
            clk_phi <= 1'b0;
            ras     <= 1'b1;
            cas     <= 1'b1;
        end
        else
        begin
            clk_cnt <= clk_nxt;
            clk_phi <= clk_nxt[3];
            ras     <= (clk_nxt[2:0] < 3'd2);  // low from clock 2 of each half
            cas     <= (clk_nxt[2:0] < 3'd5);  // low from clock 5
            if (phi_end)
            begin
                phi_cnt <= (phi_cnt == 6'(LINE_PHIS - 1)) ? '0 : phi_cnt + 6'd1;
                if (phi_cnt == 6'(LINE_PHIS - 1))
                    raster <= (raster == raster_t'(FRAME_LINES - 1)) ? '0 : raster + 9'd1;
            end
        end
    end

    // state changes only between phis, it holds for the whole next phi
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (rst)
        begin
            state <= IDLE;
            col   <= '0;
        end
        else if (phi_end)
        begin
            case (state)
                IDLE:
                    if (disp_line && phi_cnt == 6'(FETCH_FIRST - BA_LEAD - 1))
                        state <= BA_WAIT;
                BA_WAIT:
                    if (phi_cnt == 6'(FETCH_FIRST - 1))
                    begin
                        state <= FETCH;
                        col   <= '0;
                    end
                FETCH:
                    if (col == 6'(FETCH_COLS - 1))
                        state <= IDLE;  // ba rises after the last column
                    else
                        col <= col + 6'd1;
                default: state <= IDLE;
            endcase
        end
    end

    // address out for clocks 1..6 of the low half
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (rst)
        begin
            slot         <= 1'b0;
            vic_write_ab <= 1'b0;
            fetch.valid  <= 1'b0;
        end
        else
        begin
            if (clk_cnt == '0)
                slot <= take;
            vic_write_ab <= (clk_cnt == '0) ? take : (slot && clk_cnt <= 4'd5);
            fetch.valid  <= dec;  // strobe on clock 7
        end
    end

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (dec)
        begin
            fetch.pix_byte  <= dbi;  // memory settled by clock 6
            fetch.pix_color <= dbh;
        end
    end

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (rst)
            credit <= credit_t'(FIFO_DEPTH);
        else if (dec && !fetch.credit_ret)
            credit <= credit - 3'd1;
        else if (!dec && fetch.credit_ret)
            credit <= credit + 3'd1;
    end

    // returns from the encoder can never outnumber the bytes sent
    assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
        credit <= credit_t'(FIFO_DEPTH));

    assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
        vic_write_ab |-> !clk_phi);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, then look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_board_top -f src.f
./obj_dir/Vtb_board_top > sim.log
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: src.f
vic_pkg.sv
fetch_if.sv
vic_regs.sv
fetch_seq.sv
color_encoder.sv
vic_core.sv
board_top.sv
tb_board_top.sv

// File: tb_board_top.sv
`timescale 1ns/1ps

module tb_board_top;
    import vic_pkg::*;

    localparam int LINE_CLKS  = LINE_PHIS * PHI_CLKS;      // one raster line
    localparam int FRAME_CLKS = LINE_CLKS * FRAME_LINES;
    localparam int PHI_LIMIT  = 2 * PHI_CLKS;              // a phi level never lasts longer

    logic       clk_col16x_ntsc = 1'b0;
    logic       rst;
    logic       ce;
    logic       rw;
    logic [5:0] adl_IN;
    logic [7:0] dbl_IN;
    logic [3:0] dbh;
    logic       cpu_reset;
    logic       clk_phi;
    logic [5:0] adl_OUT;
    logic [5:0] adl_OE;
    logic [5:0] adh;
    logic [7:0] dbl_OUT;
    logic [7:0] dbl_OE;
    logic       irq;
    logic       aec;
    logic       ba;
    logic       cas;
    logic       ras;
    logic       ls245_addr_dir;
    logic       ls245_data_dir;
    logic       ls245_addr_oe;
    logic       ls245_data_oe;
    logic [5:0] luma;
    logic [5:0] chroma;

    integer seed;
    int     errors;
    int     timeouts;
    logic   stop_run;    // set on a timeout, later waits fall through
    byte_t  mem_byte;    // what the dram answers
    color_t mem_color;   // what the color ram answers

    board_top UUT (.*);

    always #4 clk_col16x_ntsc = ~clk_col16x_ntsc;

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_luma(input luma_t got, input luma_t exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic timeout_hit(input string what);
        timeouts++;
        stop_run = 1'b1;
        $display("timeout at %0t ns: %s", $time, what);
    endtask

    // dram and color ram only answer while the video half owns the bus
    task automatic answer_memory();
        if (!clk_phi)
        begin
            dbl_IN = mem_byte;
            dbh    = mem_color;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk_col16x_ntsc);
        answer_memory();
    endtask

    task automatic wait_phi(input logic level);
        int n;
        n = 0;
        while (clk_phi !== level && n < PHI_LIMIT && !stop_run)
        begin
            next_cycle();
            n++;
        end
        if (clk_phi !== level && !stop_run)
            timeout_hit("clk_phi stopped toggling");
    endtask

    task automatic wait_ba(input logic level);
        int n;
        n = 0;
        while (ba !== level && n < FRAME_CLKS && !stop_run)
        begin
            next_cycle();
            n++;
        end
        if (ba !== level && !stop_run)
            timeout_hit("ba never reached the expected level within a frame");
    endtask

    task automatic cpu_write(input reg_addr_e addr, input byte_t data);
        wait_phi(1'b0);
        wait_phi(1'b1);      // start of a fresh cpu half
        adl_IN = addr;
        dbl_IN = data;
        ce     = 1'b0;
        rw     = 1'b0;
        wait_phi(1'b0);      // write lands on the last high clock
        ce     = 1'b1;
        rw     = 1'b1;
    endtask

    task automatic cpu_read(input reg_addr_e addr, output byte_t data);
        int n;
        wait_phi(1'b0);
        wait_phi(1'b1);
        adl_IN = addr;
        ce     = 1'b0;
        rw     = 1'b1;
        n      = 0;
        next_cycle();
        while (dbl_OE == 8'h00 && n < PHI_LIMIT && !stop_run)
        begin
            next_cycle();
            n++;
        end
        if (dbl_OE == 8'h00 && !stop_run)
            timeout_hit("data bus never driven during a register read");
        data = dbl_OUT;
        check_byte(dbl_OE, 8'hff, "dbl_OE during read");
        check_bit(ls245_data_dir, 1'b0, "ls245_data_dir during read");
        check_bit(aec, 1'b1, "aec in the cpu half");
        wait_phi(1'b0);
        ce = 1'b1;
        check_byte(dbl_OE, 8'h00, "dbl_OE after read");  // released when phi falls
    endtask

    task automatic test_reset_state();
        check_bit(irq, 1'b1, "irq in reset");
        check_bit(ba, 1'b1, "ba in reset");
        check_byte({2'b00, adl_OE}, 8'h00, "adl_OE in reset");
        check_byte(dbl_OE, 8'h00, "dbl_OE in reset");
        check_bit(cas, 1'b1, "cas in reset");
        check_bit(ras, 1'b1, "ras in reset");
        check_luma(luma, LUMA_TAB[0], "luma in reset");
        check_bit(cpu_reset, 1'b1, "cpu_reset with rst high");
        check_bit(ls245_addr_oe, 1'b0, "ls245_addr_oe");
        check_bit(ls245_data_oe, 1'b0, "ls245_data_oe");
        check_bit(ls245_addr_dir, 1'b1, "ls245_addr_dir with no address drive");
        check_bit(ls245_data_dir, 1'b1, "ls245_data_dir with no data drive");
        rst = 1'b0;
        next_cycle();
        check_bit(cpu_reset, 1'b0, "cpu_reset after rst");
    endtask

    // unused register bits read back as ones
    task automatic test_readback();
        byte_t v;
        byte_t rd;
        v = byte_t'($random(seed));
        cpu_write(REG_BORDER, v);
        cpu_read(REG_BORDER, rd);
        check_byte(rd, {4'hf, v[3:0]}, "border readback");
        v = byte_t'($random(seed));
        cpu_write(REG_BACKGROUND, v);
        cpu_read(REG_BACKGROUND, rd);
        check_byte(rd, {4'hf, v[3:0]}, "background readback");
        v = byte_t'($random(seed));
        cpu_write(REG_VBASE, v);
        cpu_read(REG_VBASE, rd);
        check_byte(rd, {v[7:4], 4'hf}, "video base readback");
        v = byte_t'($random(seed));
        cpu_write(REG_IRQ_EN, v);
        cpu_read(REG_IRQ_EN, rd);
        check_byte(rd, {7'h7f, v[0]}, "irq enable readback");
    endtask

    task automatic test_raster_irq();
        int    n;
        byte_t rd;
        cpu_write(REG_RASTER_HI, 8'h00);
        cpu_write(REG_RASTER, 8'd5);
        cpu_write(REG_IRQ_STAT, 8'h01);   // ack the match from line 0
        cpu_write(REG_IRQ_EN, 8'h01);
        check_bit(irq, 1'b1, "irq before the compare line");
        n = 0;
        while (irq !== 1'b0 && n < FRAME_CLKS && !stop_run)
        begin
            next_cycle();
            n++;
        end
        if (irq !== 1'b0 && !stop_run)
            timeout_hit("raster interrupt never fired");
        cpu_read(REG_RASTER, rd);
        check_byte(rd, 8'd5, "raster line at interrupt");
        cpu_write(REG_IRQ_STAT, 8'h01);
        check_bit(irq, 1'b1, "irq after ack");
    endtask

    task automatic test_fetch_bus();
        byte_t  v;
        color_t base;
        int     windows;
        int     n;
        logic   was_on;
        v    = byte_t'($random(seed));
        base = v[7:4];
        cpu_write(REG_VBASE, v);
        mem_byte  = 8'h55;
        mem_color = 4'h3;
        wait_ba(1'b1);
        wait_ba(1'b0);
        for (int line = 0; line < 2; line++)
        begin
            n = 0;
            while (ba == 1'b1 && n < LINE_CLKS && !stop_run)  // gap between the two lines
            begin
                check_byte({2'b00, adl_OE}, 8'h00, "address drive while ba high");
                next_cycle();
                n++;
            end
            windows = 0;
            was_on  = 1'b0;
            n       = 0;
            while (ba == 1'b0 && n < LINE_CLKS && !stop_run)
            begin
                if (adl_OE != 6'h00)
                begin
                    check_bit(clk_phi, 1'b0, "clk_phi during address drive");
                    check_bit(aec, 1'b0, "aec during address drive");
                    check_bit(ls245_addr_dir, 1'b0, "ls245_addr_dir during address drive");
                    check_byte({2'b00, adl_OE}, 8'h3f, "adl_OE width");
                    check_byte({4'h0, adh[5:2]}, {4'h0, base}, "video base on adh");
                    if (!was_on)
                    begin
                        check_byte({adh[1:0], adl_OUT}, byte_t'(windows), "fetch column");
                        windows++;
                    end
                end
                was_on = (adl_OE != 6'h00);
                next_cycle();
                n++;
            end
            if (ba == 1'b0 && !stop_run)
                timeout_hit("ba stayed low past a whole line");
            check_byte(byte_t'(windows), byte_t'(FETCH_COLS), "fetch windows per line");
        end
    endtask

    // one display line, luma may only be the border or the other color
    task automatic scan_line_luma(input byte_t pattern, input color_t border, input color_t other);
        logic seen_border;
        logic seen_other;
        mem_byte    = pattern;
        seen_border = 1'b0;
        seen_other  = 1'b0;
        wait_ba(1'b1);
        wait_ba(1'b0);
        for (int n = 0; n < LINE_CLKS; n++)
        begin
            if (luma == LUMA_TAB[border])
            begin
                seen_border = 1'b1;
                check_luma(chroma, CHROMA_TAB[border], "border chroma");
            end
            else if (luma == LUMA_TAB[other])
            begin
                seen_other = 1'b1;
                check_luma(chroma, CHROMA_TAB[other], "pixel chroma");
            end
            else
                check_luma(luma, LUMA_TAB[other], "luma outside the allowed pair");
            next_cycle();
        end
        check_bit(seen_border, 1'b1, "border luma seen");
        check_bit(seen_other, 1'b1, "pixel luma seen");
    endtask

    task automatic test_pixels();
        cpu_write(REG_BORDER, 8'h02);
        cpu_write(REG_BACKGROUND, 8'h06);
        mem_color = 4'h7;
        scan_line_luma(8'h00, 4'h2, 4'h6);   // clear pixels show background
        scan_line_luma(8'hff, 4'h2, 4'h7);   // set pixels show the color nibble
    endtask

    initial
    begin
        seed      = 32'haefb71a1;
        errors    = 0;
        timeouts  = 0;
        stop_run  = 1'b0;
        rst       = 1'b1;
        ce        = 1'b1;
        rw        = 1'b1;
        adl_IN    = 6'h00;
        dbl_IN    = 8'h00;
        dbh       = 4'h0;
        mem_byte  = 8'h00;
        mem_color = 4'h0;
        repeat (4) @(negedge clk_col16x_ntsc);
        test_reset_state();
        test_readback();
        test_raster_irq();
        test_fetch_bus();
        test_pixels();
        $display("check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: vic_core.sv
`timescale 1ns/1ps

module vic_core (
    input  logic               clk_col16x_ntsc,
    input  logic               rst,
    input  logic               ce,
    input  logic               rw,
    input  vic_pkg::reg_addr_e adi,
    input  vic_pkg::byte_t     dbi,
    input  vic_pkg::color_t    dbh,
    output vic_pkg::byte_t     dbo,
    output vic_pkg::addr_t     ado,
    output logic               vic_write_ab,
    output logic               vic_write_db,
    output logic               clk_phi,
    output logic               aec,
    output logic               ba,
    output logic               ras,
    output logic               cas,
    output logic               irq,
    output vic_pkg::luma_t     luma,
    output vic_pkg::luma_t     chroma
);
    import vic_pkg::*;

    logic    phi_high;    // cpu half, from the sequencer
    logic    line_start;
    raster_t raster;
    color_t  video_base;
    color_t  border;
    color_t  background;

    fetch_if fetch ();    // sequencer to encoder byte stream

    // port names match the local nets, connect by name
    vic_regs u_regs (.*);

    fetch_seq u_seq (.*);

    color_encoder u_enc (.*);

endmodule

// File: vic_pkg.sv
package vic_pkg;

    // raster timing, all counts in clk_col16x_ntsc clocks or phi periods
    localparam int PHI_CLKS    = 16;   // 8 video clocks then 8 cpu clocks
    localparam int LINE_PHIS   = 64;   // ntsc line
    localparam int FRAME_LINES = 263;
    localparam int DISP_FIRST  = 48;   // first text line
    localparam int DISP_LAST   = 247;
    localparam int FETCH_FIRST = 15;   // phi of the first c-access
    localparam int FETCH_COLS  = 40;
    localparam int BA_LEAD     = 3;    // cpu is warned 3 phis ahead
    localparam int FIFO_DEPTH  = 4;    // encoder fifo, also the starting credit

    typedef logic [3:0]  color_t;   // palette index
    typedef logic [5:0]  luma_t;    // dac level, luma or chroma
    typedef logic [11:0] addr_t;
    typedef logic [8:0]  raster_t;
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  credit_t;  // 0..FIFO_DEPTH

    // cpu visible registers, low 6 address lines
    typedef enum logic [5:0] {
        REG_RASTER_HI  = 6'h11,  // bit 7 is raster bit 8
        REG_RASTER     = 6'h12,  // read line, write compare
        REG_VBASE      = 6'h18,  // video matrix base in bits 7:4
        REG_IRQ_STAT   = 6'h19,
        REG_IRQ_EN     = 6'h1a,
        REG_BORDER     = 6'h20,
        REG_BACKGROUND = 6'h21
    } reg_addr_e;

    typedef enum logic [1:0] {
        IDLE,     // no bus stealing
        BA_WAIT,  // ba low, cpu finishing its writes
        FETCH     // one c-access per phi
    } seq_state_e;

    // luma per color, greys share levels with their neighbours as on the real chip
    localparam luma_t LUMA_TAB [16] = '{
        6'd0,  6'd63, 6'd13, 6'd42,
        6'd18, 6'd34, 6'd9,  6'd50,
        6'd18, 6'd9,  6'd27, 6'd15,
        6'd27, 6'd50, 6'd27, 6'd42
    };

    // chroma amplitude, zero for black, white and greys
    localparam luma_t CHROMA_TAB [16] = '{
        6'd0,  6'd0,  6'd20, 6'd20,
        6'd24, 6'd24, 6'd20, 6'd28,
        6'd24, 6'd16, 6'd20, 6'd0,
        6'd0,  6'd24, 6'd20, 6'd0
    };

endpackage

// File: vic_regs.sv
`timescale 1ns/1ps

module vic_regs (
    input  logic               clk_col16x_ntsc,
    input  logic               rst,
    input  logic               phi_high,      // cpu half
    input  logic               ce,            // low selects the chip
    input  logic               rw,            // high reads
    input  vic_pkg::reg_addr_e adi,
    input  vic_pkg::byte_t     dbi,
    output vic_pkg::byte_t     dbo,
    output logic               vic_write_db,  // we own the data bus
    input  vic_pkg::raster_t   raster,
    input  logic               line_start,
    output vic_pkg::color_t    video_base,
    output vic_pkg::color_t    border,
    output vic_pkg::color_t    background,
    output logic               irq            // active low
);
    import vic_pkg::*;

    logic [2:0] hi_cnt;      // clocks into the high half
    logic       last_hi;
    logic       wr_now;
    raster_t    raster_cmp;
    logic       irq_stat;    // raster match latched
    logic       irq_en;
    byte_t      rd_data;

    assign last_hi = phi_high && (hi_cnt == 3'(PHI_CLKS / 2 - 1));
    assign wr_now  = last_hi && !ce && !rw;  // writes land at the very end
    assign irq     = !(irq_stat && irq_en);

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (rst || !phi_high)
            hi_cnt <= '0;
        else
            hi_cnt <= hi_cnt + 3'd1;
    end

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (rst)
        begin
            raster_cmp <= '0;
            video_base <= '0;
            border     <= '0;
            background <= '0;
            irq_en     <= 1'b0;
        end
        else if (wr_now)
        begin
            case (adi)
                REG_RASTER_HI:  raster_cmp[8]   <= dbi[7];
                REG_RASTER:     raster_cmp[7:0] <= dbi;
                REG_VBASE:      video_base      <= dbi[7:4];
                REG_IRQ_EN:     irq_en          <= dbi[0];
                REG_BORDER:     border          <= dbi[3:0];
                REG_BACKGROUND: background      <= dbi[3:0];
                default: ;  // status handled below
            endcase
        end
    end

    // compare only at the top of a line so a match fires once
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (rst)
            irq_stat <= 1'b0;
        else if (line_start && raster == raster_cmp)
            irq_stat <= 1'b1;
        else if (wr_now && adi == REG_IRQ_STAT && dbi[0])
            irq_stat <= 1'b0;  // ack by writing 1
    end

    always_comb
    begin
        case (adi)
            REG_RASTER_HI:  rd_data = {raster[8], 7'h00};
            REG_RASTER:     rd_data = raster[7:0];  // live line, not the compare
            REG_VBASE:      rd_data = {video_base, 4'hf};
            REG_IRQ_STAT:   rd_data = {!irq, 6'h3f, irq_stat};
            REG_IRQ_EN:     rd_data = {7'h7f, irq_en};
            REG_BORDER:     rd_data = {4'hf, border};
            REG_BACKGROUND: rd_data = {4'hf, background};
            default:        rd_data = 8'hff;  // unused bits read high
        endcase
    end

    // drive from the clock after ce is seen low, drop before phi falls
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (rst)
            vic_write_db <= 1'b0;
        else
            vic_write_db <= phi_high && !last_hi && !ce && rw;
    end

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (!vic_write_db)
            dbo <= rd_data;  // frozen while driving
    end

    // data bus belongs to the cpu half only, phi comes from the sequencer
    assert property (@(posedge clk_col16x_ntsc) disable iff (rst)
        vic_write_db |-> phi_high);

endmodule
